//--- source/exec_defines.svh
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// Datapath and address width
`define EXEC_RW 16

// Register file geometry
`define EXEC_REGNO 8
`define EXEC_REG_W 3

// Reset and interrupt addresses
`define EXEC_PC_RESET 16'h0000
`define EXEC_IRQ_VEC 16'h0010

// Interrupts are enabled out of reset
`define EXEC_IRQ_EN_RESET 1'b1

`endif

//--- source/exec_isa_pkg.sv
package exec_isa_pkg;

    // ALU operations
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_ADC = 3'd1,
        OP_SUB = 3'd2,
        OP_AND = 3'd3,
        OP_OR  = 3'd4,
        OP_XOR = 3'd5,
        OP_SHL = 3'd6,
        OP_SHR = 3'd7
    } alu_op_e;

    // Jump conditions, JC_NONE marks a non-jump instruction
    typedef enum logic [3:0] {
        JC_NONE   = 4'd0,
        JC_ALWAYS = 4'd1,
        JC_EQ     = 4'd2,
        JC_NE     = 4'd3,
        JC_LT     = 4'd4,
        JC_GE     = 4'd5,
        JC_CARRY  = 4'd6,
        JC_GTU    = 4'd7,
        JC_LEU    = 4'd8,
        JC_OVF    = 4'd9
    } jump_cond_e;

    typedef struct packed {
        logic c;
        logic z;
        logic n;
        logic o;
    } alu_flags_t;

endpackage

//--- source/exec_pipe_pkg.sv
`include "exec_defines.svh"

package exec_pipe_pkg;

    typedef enum logic [1:0] {
        ST_EMPTY = 2'd0,
        ST_HELD  = 2'd1,
        ST_FLUSH = 2'd2
    } ctrl_state_e;

    // Decoded instruction as handed over by decode
    typedef struct packed {
        exec_isa_pkg::alu_op_e    alu_op;
        logic [`EXEC_REG_W-1:0]   l_sel;
        logic [`EXEC_REG_W-1:0]   r_sel;
        logic                     r_imm;
        logic [`EXEC_RW-1:0]      imm;
        logic                     l_used;
        logic                     r_used;
        logic [`EXEC_REG_W-1:0]   dest;
        logic                     dest_we;
        logic                     flags_we;
        exec_isa_pkg::jump_cond_e jump_cond;
        logic                     jump_predict;
        logic                     irt;
    } exec_instr_t;

endpackage

//--- source/exec_ctl_if.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

interface exec_ctl_if;

    logic                fire;
    logic                irq_take;
    logic                irt_take;
    logic [`EXEC_RW-1:0] irq_pc;
    logic                jump_taken;
    logic                mispredict;

    // Control side decides what happens this cycle
    modport ctrl (output fire, irq_take, irt_take, irq_pc, input jump_taken, mispredict);

    // Datapath side follows those decisions and reports the jump outcome
    modport datapath (input fire, irq_take, irt_take, irq_pc, output jump_taken, mispredict);

endinterface

//--- source/exec_ctrl.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module exec_ctrl (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic                       i_submit,
    input  exec_pipe_pkg::exec_instr_t i_instr,
    input  logic                       i_next_ready,
    input  logic                       i_irq,
    input  logic                       i_result_valid,
    input  logic [`EXEC_REG_W-1:0]     i_result_dest,
    input  logic [`EXEC_RW-1:0]        i_pc,
    exec_ctl_if.ctrl                   ctl,
    output logic                       o_ready,
    output logic                       o_flush,
    output exec_pipe_pkg::exec_instr_t o_instr
);

    exec_pipe_pkg::ctrl_state_e state_q;
    exec_pipe_pkg::ctrl_state_e state_d;
    exec_pipe_pkg::exec_instr_t held_q;
    logic                       in_valid;
    logic                       pending;
    logic                       hazard;
    logic                       flush_d;
    logic                       irq_en_q;
    logic [`EXEC_RW-1:0]        irq_pc_q;

    // New instructions are discarded while the flush is visible
    assign in_valid = i_submit && (state_q != exec_pipe_pkg::ST_FLUSH);
    assign pending  = in_valid || (state_q == exec_pipe_pkg::ST_HELD);
    assign o_instr  = in_valid ? i_instr : held_q;

    // Result in flight is written back at the next edge, no bypass
    assign hazard = i_result_valid &&
                    ((o_instr.l_used && (o_instr.l_sel == i_result_dest)) ||
                     (o_instr.r_used && (o_instr.r_sel == i_result_dest)));

    assign ctl.irq_take = i_irq && irq_en_q && (state_q != exec_pipe_pkg::ST_FLUSH);
    assign ctl.fire     = pending && i_next_ready && !hazard && !ctl.irq_take;
    assign ctl.irt_take = ctl.fire && o_instr.irt;
    assign ctl.irq_pc   = irq_pc_q;

    assign o_ready = ctl.fire || !pending || ctl.irq_take;
    assign o_flush = (state_q == exec_pipe_pkg::ST_FLUSH);

    assign flush_d = ctl.irq_take || (ctl.fire && (ctl.mispredict || o_instr.irt));

    always_comb begin
        if (flush_d) begin
            state_d = exec_pipe_pkg::ST_FLUSH;
        end else if (pending && !ctl.fire) begin
            state_d = exec_pipe_pkg::ST_HELD;
        end else begin
            state_d = exec_pipe_pkg::ST_EMPTY;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state_q <= exec_pipe_pkg::ST_EMPTY;
        end else begin
            state_q <= state_d;
        end
    end

    // Keep the waiting instruction, a fresh offer replaces it
    always_ff @(posedge i_clk) begin
        if (state_d == exec_pipe_pkg::ST_HELD) begin
            held_q <= o_instr;
        end
    end

    // Interrupt enable and return address
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            irq_en_q <= `EXEC_IRQ_EN_RESET;
            irq_pc_q <= `EXEC_PC_RESET;
        end else if (ctl.irq_take) begin
            irq_en_q <= 1'b0;
            irq_pc_q <= i_pc;
        end else if (ctl.irt_take) begin
            irq_en_q <= 1'b1;
        end
    end

    a_flush_one_cycle: assert property (@(posedge i_clk) disable iff (i_rst)
        o_flush |=> !o_flush);

    a_no_fire_in_flush: assert property (@(posedge i_clk) disable iff (i_rst)
        (state_q == exec_pipe_pkg::ST_FLUSH) |-> !ctl.fire);

endmodule

//--- source/exec_pc.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module exec_pc (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic [`EXEC_RW-1:0] i_target,
    exec_ctl_if.datapath        ctl,
    output logic [`EXEC_RW-1:0] o_pc
);

    logic [`EXEC_RW-1:0] pc_q;

    // Interrupt entry wins over anything executing
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc_q <= `EXEC_PC_RESET;
        end else if (ctl.irq_take) begin
            pc_q <= `EXEC_IRQ_VEC;
        end else if (ctl.fire) begin
            if (ctl.irt_take) begin
                pc_q <= ctl.irq_pc;
            end else if (ctl.jump_taken) begin
                pc_q <= i_target;
            end else begin
                pc_q <= pc_q + `EXEC_RW'd1;
            end
        end
    end

    assign o_pc = pc_q;

endmodule

//--- source/exec_regfile.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module exec_regfile (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic [`EXEC_REG_W-1:0] i_l_sel,
    input  logic [`EXEC_REG_W-1:0] i_r_sel,
    input  logic                   i_wb_en,
    input  logic [`EXEC_REG_W-1:0] i_wb_sel,
    input  logic [`EXEC_RW-1:0]    i_wb_data,
    output logic [`EXEC_RW-1:0]    o_l,
    output logic [`EXEC_RW-1:0]    o_r
);

    logic [`EXEC_RW-1:0] regs_q [`EXEC_REGNO];

    // Single write-back port from the memory stage
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < `EXEC_REGNO; i++) begin
                regs_q[i] <= '0;
            end
        end else if (i_wb_en) begin
            regs_q[i_wb_sel] <= i_wb_data;
        end
    end

    // Reads see the old value during a write
    assign o_l = regs_q[i_l_sel];
    assign o_r = regs_q[i_r_sel];

endmodule

//--- source/exec_alu.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module exec_alu (
    input  exec_isa_pkg::alu_op_e    i_op,
    input  logic [`EXEC_RW-1:0]      i_l,
    input  logic [`EXEC_RW-1:0]      i_r,
    input  logic                     i_carry,
    output logic [`EXEC_RW-1:0]      o_result,
    output exec_isa_pkg::alu_flags_t o_flags
);

    // Top bit holds carry out, or borrow for subtract
    logic [`EXEC_RW:0] wide;
    logic              l_msb;
    logic              r_msb;
    logic              res_msb;

    always_comb begin
        case (i_op)
            exec_isa_pkg::OP_ADD: wide = {1'b0, i_l} + {1'b0, i_r};
            exec_isa_pkg::OP_ADC: wide = {1'b0, i_l} + {1'b0, i_r} + {{`EXEC_RW{1'b0}}, i_carry};
            exec_isa_pkg::OP_SUB: wide = {1'b0, i_l} - {1'b0, i_r};
            exec_isa_pkg::OP_AND: wide = {1'b0, i_l & i_r};
            exec_isa_pkg::OP_OR:  wide = {1'b0, i_l | i_r};
            exec_isa_pkg::OP_XOR: wide = {1'b0, i_l ^ i_r};
            exec_isa_pkg::OP_SHL: wide = {i_l, 1'b0};
            default:              wide = {i_l[0], 1'b0, i_l[`EXEC_RW-1:1]};
        endcase
    end

    assign l_msb   = i_l[`EXEC_RW-1];
    assign r_msb   = i_r[`EXEC_RW-1];
    assign res_msb = wide[`EXEC_RW-1];

    assign o_result  = wide[`EXEC_RW-1:0];
    assign o_flags.c = wide[`EXEC_RW];
    assign o_flags.z = (wide[`EXEC_RW-1:0] == '0);
    assign o_flags.n = res_msb;

    // Signed overflow only for the arithmetic ops
    always_comb begin
        case (i_op)
            exec_isa_pkg::OP_ADD,
            exec_isa_pkg::OP_ADC: o_flags.o = (l_msb == r_msb) && (res_msb != l_msb);
            exec_isa_pkg::OP_SUB: o_flags.o = (l_msb != r_msb) && (res_msb != l_msb);
            default:              o_flags.o = 1'b0;
        endcase
    end

endmodule

//--- source/exec_branch.sv
`timescale 1ns/1ps

module exec_branch (
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  exec_isa_pkg::jump_cond_e i_cond,
    input  logic                     i_predict,
    input  logic                     i_flags_we,
    input  exec_isa_pkg::alu_flags_t i_new_flags,
    exec_ctl_if.datapath             ctl,
    output exec_isa_pkg::alu_flags_t o_flags
);

    exec_isa_pkg::alu_flags_t flags_q;
    logic                     taken;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            flags_q <= '0;
        end else if (ctl.fire && i_flags_we) begin
            flags_q <= i_new_flags;
        end
    end

    // Conditions look at flags from earlier instructions only
    always_comb begin
        case (i_cond)
            exec_isa_pkg::JC_ALWAYS: taken = 1'b1;
            exec_isa_pkg::JC_EQ:     taken = flags_q.z;
            exec_isa_pkg::JC_NE:     taken = !flags_q.z;
            exec_isa_pkg::JC_LT:     taken = flags_q.n;
            exec_isa_pkg::JC_GE:     taken = !flags_q.n;
            exec_isa_pkg::JC_CARRY:  taken = flags_q.c;
            exec_isa_pkg::JC_GTU:    taken = !(flags_q.c || flags_q.z);
            exec_isa_pkg::JC_LEU:    taken = flags_q.c || flags_q.z;
            exec_isa_pkg::JC_OVF:    taken = flags_q.o;
            default:                 taken = 1'b0;
        endcase
    end

    assign ctl.jump_taken = taken;
    assign ctl.mispredict = (i_cond != exec_isa_pkg::JC_NONE) && (taken != i_predict);
    assign o_flags        = flags_q;

endmodule

//--- source/exec_stage_top.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module exec_stage_top (
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  logic                     i_submit,
    input  exec_isa_pkg::alu_op_e    i_alu_op,
    input  logic [`EXEC_REG_W-1:0]   i_l_sel,
    input  logic [`EXEC_REG_W-1:0]   i_r_sel,
    input  logic                     i_r_imm,
    input  logic [`EXEC_RW-1:0]      i_imm,
    input  logic                     i_l_used,
    input  logic                     i_r_used,
    input  logic [`EXEC_REG_W-1:0]   i_dest,
    input  logic                     i_dest_we,
    input  logic                     i_flags_we,
    input  exec_isa_pkg::jump_cond_e i_jump_cond,
    input  logic                     i_jump_predict,
    input  logic                     i_irt,
    output logic                     o_ready,
    output logic                     o_flush,
    input  logic                     i_next_ready,
    input  logic                     i_irq,
    output logic                     o_pc_update,
    output logic [`EXEC_RW-1:0]      o_exec_pc,
    output logic                     o_submit,
    output logic [`EXEC_RW-1:0]      o_data,
    output logic [`EXEC_REG_W-1:0]   o_reg_dest,
    output logic                     o_reg_we,
    input  logic                     i_wb_en,
    input  logic [`EXEC_REG_W-1:0]   i_wb_sel,
    input  logic [`EXEC_RW-1:0]      i_wb_data
);

    exec_pipe_pkg::exec_instr_t in_instr;
    exec_pipe_pkg::exec_instr_t ex_instr;
    logic [`EXEC_RW-1:0]        l_data;
    logic [`EXEC_RW-1:0]        r_data;
    logic [`EXEC_RW-1:0]        r_operand;
    logic [`EXEC_RW-1:0]        alu_result;
    exec_isa_pkg::alu_flags_t   alu_flags;
    exec_isa_pkg::alu_flags_t   stored_flags;

    exec_ctl_if ctl0 ();

    assign in_instr = '{alu_op: i_alu_op, l_sel: i_l_sel, r_sel: i_r_sel, r_imm: i_r_imm,
                        imm: i_imm, l_used: i_l_used, r_used: i_r_used, dest: i_dest,
                        dest_we: i_dest_we, flags_we: i_flags_we, jump_cond: i_jump_cond,
                        jump_predict: i_jump_predict, irt: i_irt};

    exec_ctrl ctrl0 (
        .i_clk(i_clk), .i_rst(i_rst), .i_submit(i_submit), .i_instr(in_instr),
        .i_next_ready(i_next_ready), .i_irq(i_irq),
        .i_result_valid(o_submit && o_reg_we), .i_result_dest(o_reg_dest),
        .i_pc(o_exec_pc), .ctl(ctl0.ctrl),
        .o_ready(o_ready), .o_flush(o_flush), .o_instr(ex_instr)
    );

    exec_regfile rf0 (
        .i_clk(i_clk), .i_rst(i_rst), .i_l_sel(ex_instr.l_sel), .i_r_sel(ex_instr.r_sel),
        .i_wb_en(i_wb_en), .i_wb_sel(i_wb_sel), .i_wb_data(i_wb_data),
        .o_l(l_data), .o_r(r_data)
    );

    assign r_operand = ex_instr.r_imm ? ex_instr.imm : r_data;

    exec_alu alu0 (
        .i_op(ex_instr.alu_op), .i_l(l_data), .i_r(r_operand), .i_carry(stored_flags.c),
        .o_result(alu_result), .o_flags(alu_flags)
    );

    exec_branch br0 (
        .i_clk(i_clk), .i_rst(i_rst), .i_cond(ex_instr.jump_cond),
        .i_predict(ex_instr.jump_predict), .i_flags_we(ex_instr.flags_we),
        .i_new_flags(alu_flags), .ctl(ctl0.datapath), .o_flags(stored_flags)
    );

    // Jump target is the ALU result
    exec_pc pc0 (
        .i_clk(i_clk), .i_rst(i_rst), .i_target(alu_result), .ctl(ctl0.datapath),
        .o_pc(o_exec_pc)
    );

    assign o_pc_update = ctl0.fire;

    // Result strobe to the memory stage
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_submit <= 1'b0;
            o_reg_we <= 1'b0;
        end else begin
            o_submit <= ctl0.fire;
            o_reg_we <= ctl0.fire && ex_instr.dest_we;
        end
    end

    always_ff @(posedge i_clk) begin
        if (ctl0.fire) begin
            o_data     <= alu_result;
            o_reg_dest <= ex_instr.dest;
        end
    end

    a_submit_follows_fire: assert property (@(posedge i_clk) disable iff (i_rst)
        1'b1 |=> (o_submit == $past(ctl0.fire)));

endmodule

//--- sim/tb_exec_stage.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module tb_exec_stage;

    // Roughly ten times the cycles the directed tests need
    localparam int MAX_CYCLES = 2000;

    logic i_clk, i_rst, i_submit, i_r_imm, i_l_used, i_r_used, i_dest_we, i_flags_we;
    logic i_jump_predict, i_irt, i_next_ready, i_irq, i_wb_en;
    exec_isa_pkg::alu_op_e    i_alu_op;
    exec_isa_pkg::jump_cond_e i_jump_cond;
    logic [`EXEC_REG_W-1:0] i_l_sel, i_r_sel, i_dest, i_wb_sel, o_reg_dest;
    logic [`EXEC_RW-1:0]    i_imm, i_wb_data, o_exec_pc, o_data;
    logic o_ready, o_flush, o_pc_update, o_submit, o_reg_we;

    // Reference model state
    logic [`EXEC_RW-1:0]      m_regs [`EXEC_REGNO];
    exec_isa_pkg::alu_flags_t m_flags;
    logic [`EXEC_RW-1:0]      m_pc, m_saved_pc, exp_data;
    logic [`EXEC_REG_W-1:0]   exp_dest;
    logic                     m_irq_en, exp_we, exp_flush;
    logic [31:0]              seed;

    exec_stage_top dut0 (.*);

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    initial begin
        repeat (MAX_CYCLES) @(posedge i_clk);
        $display("Timeout after %0d cycles, the DUT stopped responding", MAX_CYCLES);
        $display("Regression failed");
        $fatal(1, "watchdog expired");
    end

    // Memory stage stand-in writes back each result in its o_submit cycle
    initial begin
        i_wb_en = 1'b0;
        i_wb_sel = '0;
        i_wb_data = '0;
        forever begin
            @(posedge i_clk);
            #1;
            i_wb_en = o_submit && o_reg_we;
            i_wb_sel = o_reg_dest;
            i_wb_data = o_data;
        end
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    function automatic logic [`EXEC_REG_W-1:0] rand_sel();
        logic [31:0] r;
        r = lcg_next();
        return r[18:16];
    endfunction

    function automatic logic [`EXEC_RW-1:0] rand_word();
        logic [31:0] r;
        r = lcg_next();
        return r[31:16];
    endfunction

    // Returns {c, z, n, o, result}
    function automatic logic [`EXEC_RW+3:0] ref_alu(exec_isa_pkg::alu_op_e op,
                                                    logic [`EXEC_RW-1:0] l,
                                                    logic [`EXEC_RW-1:0] r, logic cin);
        logic [`EXEC_RW:0]   sum;
        logic [`EXEC_RW-1:0] res;
        logic                c;
        logic                o;
        c = 1'b0;
        o = 1'b0;
        case (op)
            exec_isa_pkg::OP_ADD, exec_isa_pkg::OP_ADC: begin
                sum = {1'b0, l} + {1'b0, r};
                if (op == exec_isa_pkg::OP_ADC && cin) sum = sum + 1'b1;
                res = sum[`EXEC_RW-1:0];
                c = sum[`EXEC_RW];
                o = (l[`EXEC_RW-1] == r[`EXEC_RW-1]) && (res[`EXEC_RW-1] != l[`EXEC_RW-1]);
            end
            exec_isa_pkg::OP_SUB: begin
                res = l - r;
                c = (l < r);
                o = (l[`EXEC_RW-1] != r[`EXEC_RW-1]) && (res[`EXEC_RW-1] != l[`EXEC_RW-1]);
            end
            exec_isa_pkg::OP_AND: res = l & r;
            exec_isa_pkg::OP_OR:  res = l | r;
            exec_isa_pkg::OP_XOR: res = l ^ r;
            exec_isa_pkg::OP_SHL: begin
                res = {l[`EXEC_RW-2:0], 1'b0};
                c = l[`EXEC_RW-1];
            end
            default: begin
                res = {1'b0, l[`EXEC_RW-1:1]};
                c = l[0];
            end
        endcase
        return {c, (res == '0), res[`EXEC_RW-1], o, res};
    endfunction

    function automatic logic cond_taken(exec_isa_pkg::jump_cond_e cond,
                                        exec_isa_pkg::alu_flags_t f);
        case (cond)
            exec_isa_pkg::JC_ALWAYS: return 1'b1;
            exec_isa_pkg::JC_EQ:     return f.z;
            exec_isa_pkg::JC_NE:     return !f.z;
            exec_isa_pkg::JC_LT:     return f.n;
            exec_isa_pkg::JC_GE:     return !f.n;
            exec_isa_pkg::JC_CARRY:  return f.c;
            exec_isa_pkg::JC_GTU:    return !f.c && !f.z;
            exec_isa_pkg::JC_LEU:    return f.c || f.z;
            exec_isa_pkg::JC_OVF:    return f.o;
            default:                 return 1'b0;
        endcase
    endfunction

    function automatic exec_pipe_pkg::exec_instr_t make_instr(
            exec_isa_pkg::alu_op_e op, logic [`EXEC_REG_W-1:0] l, logic [`EXEC_REG_W-1:0] r,
            logic r_imm, logic [`EXEC_RW-1:0] imm, logic [`EXEC_REG_W-1:0] dest,
            logic dest_we, logic flags_we, exec_isa_pkg::jump_cond_e cond, logic pred,
            logic irt);
        exec_pipe_pkg::exec_instr_t t;
        t = '{alu_op: op, l_sel: l, r_sel: r, r_imm: r_imm, imm: imm, l_used: 1'b1,
              r_used: !r_imm, dest: dest, dest_we: dest_we, flags_we: flags_we,
              jump_cond: cond, jump_predict: pred, irt: irt};
        return t;
    endfunction

    task automatic check_equal(string name, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s expected %0h actual %0h", name, exp, act);
            $display("Regression failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic drive_instr(exec_pipe_pkg::exec_instr_t t);
        i_alu_op = t.alu_op;
        i_l_sel = t.l_sel;
        i_r_sel = t.r_sel;
        i_r_imm = t.r_imm;
        i_imm = t.imm;
        i_l_used = t.l_used;
        i_r_used = t.r_used;
        i_dest = t.dest;
        i_dest_we = t.dest_we;
        i_flags_we = t.flags_we;
        i_jump_cond = t.jump_cond;
        i_jump_predict = t.jump_predict;
        i_irt = t.irt;
    endtask

    // Model update for an instruction executing with the current state
    task automatic model_fire(exec_pipe_pkg::exec_instr_t t);
        logic [`EXEC_RW-1:0] lv;
        logic [`EXEC_RW-1:0] rv;
        logic [`EXEC_RW+3:0] out;
        logic                taken;
        lv = m_regs[t.l_sel];
        rv = t.r_imm ? t.imm : m_regs[t.r_sel];
        out = ref_alu(t.alu_op, lv, rv, m_flags.c);
        taken = cond_taken(t.jump_cond, m_flags);
        exp_data = out[`EXEC_RW-1:0];
        exp_dest = t.dest;
        exp_we = t.dest_we;
        exp_flush = t.irt || ((t.jump_cond != exec_isa_pkg::JC_NONE) && (taken != t.jump_predict));
        if (t.irt) begin
            m_pc = m_saved_pc;
            m_irq_en = 1'b1;
        end else if (taken) begin
            m_pc = out[`EXEC_RW-1:0];
        end else begin
            m_pc = m_pc + 1'b1;
        end
        if (t.flags_we) m_flags = exec_isa_pkg::alu_flags_t'(out[`EXEC_RW+3:`EXEC_RW]);
        if (t.dest_we) m_regs[t.dest] = out[`EXEC_RW-1:0];
    endtask

    task automatic expect_result(string name);
        check_equal({name, " o_submit"}, 32'd1, 32'(o_submit));
        check_equal({name, " o_data"}, 32'(exp_data), 32'(o_data));
        check_equal({name, " o_reg_dest"}, 32'(exp_dest), 32'(o_reg_dest));
        check_equal({name, " o_reg_we"}, 32'(exp_we), 32'(o_reg_we));
        check_equal({name, " o_exec_pc"}, 32'(m_pc), 32'(o_exec_pc));
        check_equal({name, " o_flush"}, 32'(exp_flush), 32'(o_flush));
    endtask

    // Entered and left 1 ns after a rising edge
    task automatic idle_cycle();
        @(posedge i_clk);
        #1;
    endtask

    task automatic run_instr(string name, exec_pipe_pkg::exec_instr_t t, output int stall);
        drive_instr(t);
        i_submit = 1'b1;
        stall = 0;
        @(negedge i_clk);
        while (!o_pc_update) begin
            check_equal({name, " o_ready while held"}, 32'd0, 32'(o_ready));
            stall++;
            idle_cycle();
            i_submit = 1'b0;
            @(negedge i_clk);
        end
        check_equal({name, " o_ready on fire"}, 32'd1, 32'(o_ready));
        model_fire(t);
        idle_cycle();
        i_submit = 1'b0;
        expect_result(name);
    endtask

    // Offer an instruction in the flush cycle and confirm it never executes
    task automatic drop_in_flush(string name);
        drive_instr(make_instr(exec_isa_pkg::OP_ADD, 1, 2, 0, 0, 3, 1, 1,
                               exec_isa_pkg::JC_NONE, 0, 0));
        i_submit = 1'b1;
        @(negedge i_clk);
        check_equal({name, " fire in flush"}, 32'd0, 32'(o_pc_update));
        idle_cycle();
        i_submit = 1'b0;
        check_equal({name, " result after flush"}, 32'd0, 32'(o_submit));
        check_equal({name, " pc after flush"}, 32'(m_pc), 32'(o_exec_pc));
        @(negedge i_clk);
        check_equal({name, " dropped instr fired"}, 32'd0, 32'(o_pc_update));
        idle_cycle();
    endtask

    task automatic take_irq(string name);
        drive_instr(make_instr(exec_isa_pkg::OP_OR, 4, 0, 1, 16'h00ff, 4, 1, 1,
                               exec_isa_pkg::JC_NONE, 0, 0));
        i_submit = 1'b1;
        i_irq = 1'b1;
        @(negedge i_clk);
        check_equal({name, " fire with irq"}, 32'd0, 32'(o_pc_update));
        m_saved_pc = m_pc;
        m_pc = `EXEC_IRQ_VEC;
        m_irq_en = 1'b0;
        idle_cycle();
        i_submit = 1'b0;
        i_irq = 1'b0;
        check_equal({name, " o_flush"}, 32'd1, 32'(o_flush));
        check_equal({name, " o_exec_pc"}, 32'(m_pc), 32'(o_exec_pc));
        check_equal({name, " o_submit"}, 32'd0, 32'(o_submit));
        idle_cycle();
        check_equal({name, " dropped instr"}, 32'd0, 32'(o_submit));
        check_equal({name, " flush length"}, 32'd0, 32'(o_flush));
    endtask

    task automatic verify_reset_state();
        check_equal("reset o_submit", 32'd0, 32'(o_submit));
        check_equal("reset o_flush", 32'd0, 32'(o_flush));
        check_equal("reset o_pc_update", 32'd0, 32'(o_pc_update));
        check_equal("reset o_exec_pc", 32'(`EXEC_PC_RESET), 32'(o_exec_pc));
    endtask

    task automatic exercise_alu_ops();
        int stall;
        // Seed every register with a random value first
        for (int k = 0; k < `EXEC_REGNO; k++) begin
            run_instr("alu seed", make_instr(exec_isa_pkg::OP_OR, 3'(k), 0, 1, rand_word(),
                      3'(k), 1, 0, exec_isa_pkg::JC_NONE, 0, 0), stall);
        end
        for (int i = 0; i < 16; i++) begin
            run_instr("alu op", make_instr(exec_isa_pkg::alu_op_e'(i[2:0]), rand_sel(),
                      rand_sel(), i >= 8, rand_word(), rand_sel(), 1, 1,
                      exec_isa_pkg::JC_NONE, 0, 0), stall);
        end
    endtask

    task automatic chain_dependent_instrs();
        int stall;
        idle_cycle();
        run_instr("hazard first", make_instr(exec_isa_pkg::OP_ADD, 1, 2, 0, 0, 5, 1, 0,
                  exec_isa_pkg::JC_NONE, 0, 0), stall);
        run_instr("hazard second", make_instr(exec_isa_pkg::OP_XOR, 5, 3, 0, 0, 6, 1, 0,
                  exec_isa_pkg::JC_NONE, 0, 0), stall);
        check_equal("hazard stall cycles", 32'd1, 32'(stall));
        // 0xffff + 1 sets carry and ADC then adds it to zero
        run_instr("carry set", make_instr(exec_isa_pkg::OP_OR, 6, 0, 1, 16'hffff, 6, 1, 0,
                  exec_isa_pkg::JC_NONE, 0, 0), stall);
        run_instr("carry add", make_instr(exec_isa_pkg::OP_ADD, 6, 0, 1, 16'h0001, 6, 1, 1,
                  exec_isa_pkg::JC_NONE, 0, 0), stall);
        run_instr("carry adc", make_instr(exec_isa_pkg::OP_ADC, 6, 0, 1, 16'h0000, 7, 1, 1,
                  exec_isa_pkg::JC_NONE, 0, 0), stall);
        check_equal("adc carry in", 32'd1, 32'(o_data));
        check_equal("adc stall cycles", 32'd1, 32'(stall));
    endtask

    task automatic compare_and_jump();
        int                       stall;
        logic                     taken;
        logic                     pred;
        exec_isa_pkg::jump_cond_e cond;
        logic [`EXEC_REG_W-1:0]   a;
        for (int pass = 0; pass < 2; pass++) begin
            idle_cycle();
            a = rand_sel();
            // Second pass compares a register with itself
            run_instr("compare", make_instr(exec_isa_pkg::OP_SUB, a, pass == 1 ? a : rand_sel(),
                      0, 0, 0, 0, 1, exec_isa_pkg::JC_NONE, 0, 0), stall);
            for (int k = 1; k <= 9; k++) begin
                cond = exec_isa_pkg::jump_cond_e'(k);
                taken = cond_taken(cond, m_flags);
                pred = k[0] ? taken : !taken;
                run_instr("jump", make_instr(exec_isa_pkg::OP_OR, rand_sel(), 0, 1, rand_word(),
                          0, 0, 0, cond, pred, 0), stall);
                if (pred != taken) drop_in_flush("mispredict");
            end
        end
    endtask

    task automatic enter_and_leave_irq();
        int stall;
        idle_cycle();
        take_irq("irq entry");
        // Interrupts are now disabled
        i_irq = 1'b1;
        idle_cycle();
        i_irq = 1'b0;
        check_equal("second irq flush", 32'(m_irq_en), 32'(o_flush));
        check_equal("second irq pc", 32'(m_pc), 32'(o_exec_pc));
        run_instr("handler", make_instr(exec_isa_pkg::OP_ADD, 1, 0, 1, 16'h0003, 2, 1, 0,
                  exec_isa_pkg::JC_NONE, 0, 0), stall);
        run_instr("irq return", make_instr(exec_isa_pkg::OP_ADD, 0, 0, 1, 0, 0, 0, 0,
                  exec_isa_pkg::JC_NONE, 0, 1), stall);
        drop_in_flush("irq return");
        take_irq("irq again");
    endtask

    task automatic hold_under_backpressure();
        exec_pipe_pkg::exec_instr_t t;
        idle_cycle();
        t = make_instr(exec_isa_pkg::OP_XOR, rand_sel(), rand_sel(), 0, 0, rand_sel(), 1, 1,
                       exec_isa_pkg::JC_NONE, 0, 0);
        i_next_ready = 1'b0;
        drive_instr(t);
        i_submit = 1'b1;
        repeat (4) begin
            @(negedge i_clk);
            check_equal("stalled o_ready", 32'd0, 32'(o_ready));
            check_equal("stalled fire", 32'd0, 32'(o_pc_update));
            idle_cycle();
            i_submit = 1'b0;
            check_equal("stalled o_submit", 32'd0, 32'(o_submit));
        end
        i_next_ready = 1'b1;
        @(negedge i_clk);
        check_equal("released fire", 32'd1, 32'(o_pc_update));
        model_fire(t);
        idle_cycle();
        expect_result("released");
        idle_cycle();
        check_equal("single result", 32'd0, 32'(o_submit));
    endtask

    initial begin
        seed = 32'h7765;
        i_rst = 1'b1;
        i_submit = 1'b0;
        i_next_ready = 1'b1;
        i_irq = 1'b0;
        drive_instr('0);
        for (int k = 0; k < `EXEC_REGNO; k++) m_regs[k] = '0;
        m_flags = '0;
        m_pc = `EXEC_PC_RESET;
        m_saved_pc = `EXEC_PC_RESET;
        m_irq_en = `EXEC_IRQ_EN_RESET;
        repeat (5) @(posedge i_clk);
        #1;
        i_rst = 1'b0;
        verify_reset_state();
        exercise_alu_ops();
        chain_dependent_instrs();
        compare_and_jump();
        enter_and_leave_irq();
        hold_under_backpressure();
        $display("Regression passed");
        $finish;
    end

endmodule

//--- project.f
+incdir+source
source/exec_isa_pkg.sv
source/exec_pipe_pkg.sv
source/exec_ctl_if.sv
source/exec_ctrl.sv
source/exec_pc.sv
source/exec_regfile.sv
source/exec_alu.sv
source/exec_branch.sv
source/exec_stage_top.sv
sim/tb_exec_stage.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_exec_stage
FILELIST  := project.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert
LINTFLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
